// File: bench/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "csr_fields.svh"

module fetch_unit_tb;
    import fetch_pkg::*;

    localparam addr_t reset_pc        = 32'h1c00_0000;
    localparam int    tlb_entries     = 16;
    localparam inst_t key             = 32'h5a5a_0000;
    localparam int    max_wait_cycles = 1000;
    localparam int    map_direct      = 0;
    localparam int    map_dmw         = 1;
    localparam int    map_tlb         = 2;

    logic                           clk;
    logic                           reset;
    redirect_t                      redirect;
    csr_view_t                      csr;
    logic                           ds_allowin;
    logic                           tlb_we;
    logic [$clog2(tlb_entries)-1:0] tlb_windex;
    tlb_entry_t                     tlb_wentry;
    logic                           addr_ok;
    logic                           data_ok;
    inst_t                          rdata;
    logic                           fs_to_ds_valid;
    fetch_out_t                     fs_to_ds;
    logic                           inst_sram_req;
    addr_t                          inst_sram_addr;

    fetch_out_t  out_q [$];
    addr_t       last_out_pc;
    addr_t       old_seq_pc;
    logic [31:0] rand_state;
    // current translation seen by the expected-value model
    int          map_mode;
    logic [2:0]  map_pseg;
    ppn_t        map_ppn;
    logic        map_huge;

    fetch_unit #(
        .reset_pc    (reset_pc),
        .tlb_entries (tlb_entries)
    ) fetch_unit_inst (
        .clk               (clk),
        .reset             (reset),
        .redirect          (redirect),
        .csr               (csr),
        .ds_allowin        (ds_allowin),
        .tlb_we            (tlb_we),
        .tlb_windex        (tlb_windex),
        .tlb_wentry        (tlb_wentry),
        .inst_sram_addr_ok (addr_ok),
        .inst_sram_data_ok (data_ok),
        .inst_sram_rdata   (rdata),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds          (fs_to_ds),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr)
    );

    inst_mem_model #(
        .seed (4783),
        .key  (key)
    ) mem_model (
        .clk     (clk),
        .reset   (reset),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // every transfer to decode goes into the queue
    always @(posedge clk) begin
        if (reset) begin
            last_out_pc = reset_pc - 32'd4;
        end else if (fs_to_ds_valid) begin
            out_q.push_back(fs_to_ds);
            last_out_pc = fs_to_ds.pc;
        end
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic logic random_ready();
        logic [31:0] r;
        r = next_random();
        return r[17:16] != 2'b00;
    endfunction

    function automatic addr_t expected_pa(input addr_t va);
        if (map_mode == map_dmw) begin
            return {map_pseg, va[28:0]};
        end else if (map_mode == map_tlb) begin
            return map_huge ? {map_ppn[19:10], va[21:0]} : {map_ppn, va[11:0]};
        end
        return va;
    endfunction

    function automatic logic [31:0] crmd_value(input plv_t plv, input logic da, input logic pg);
        logic [31:0] v;
        v            = '0;
        v[`CRMD_PLV] = plv;
        v[`CRMD_DA]  = da;
        v[`CRMD_PG]  = pg;
        return v;
    endfunction

    // window open for plv0 only
    function automatic logic [31:0] dmw_value(input logic [2:0] vseg, input logic [2:0] pseg);
        logic [31:0] v;
        v             = '0;
        v[`DMW_PLV0]  = 1'b1;
        v[`DMW_VSEG]  = vseg;
        v[`DMW_PSEG]  = pseg;
        return v;
    endfunction

    function automatic tlb_entry_t page_entry(input addr_t va, input ppn_t ppn,
                                              input logic huge, input logic v, input plv_t plv);
        tlb_entry_t e;
        e      = '0;
        e.vppn = va[31:13];
        e.huge = huge;
        e.g    = 1'b1;
        e.e    = 1'b1;
        e.ppn  = ppn;
        e.plv  = plv;
        e.v    = v;
        return e;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_ecode(input string name, input ecode_t exp, input ecode_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_output(input string name, input fetch_out_t o, input addr_t exp_pc,
                                input logic exp_ex, input ecode_t exp_ecode);
        check_addr({name, " pc"}, exp_pc, o.pc);
        check_flag({name, " ex"}, exp_ex, o.ex);
        if (exp_ex) begin
            check_ecode({name, " ecode"}, exp_ecode, o.ecode);
        end else begin
            check_inst({name, " inst"}, expected_pa(exp_pc) ^ key, o.inst);
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) step();
        reset = 1'b0;
    endtask

    task automatic write_tlb(input logic [$clog2(tlb_entries)-1:0] idx, input tlb_entry_t entry);
        tlb_we     = 1'b1;
        tlb_windex = idx;
        tlb_wentry = entry;
        step();
        tlb_we = 1'b0;
    endtask

    task automatic wait_outputs(input string name, input int n, input logic toggle);
        int cycles;
        cycles = 0;
        while (out_q.size() < n) begin
            if (cycles == max_wait_cycles) begin
                abort_run($sformatf("%s: fewer than %0d instructions reached decode in time",
                                    name, n));
            end
            step();
            cycles++;
            if (toggle) begin
                ds_allowin = random_ready();
            end
        end
    endtask

    // one-cycle redirect with br_cancel alongside br_taken
    task automatic send_redirect(input logic flush, input logic taken,
                                 input addr_t f_target, input addr_t b_target);
        step();
        out_q.delete();
        old_seq_pc             = last_out_pc + 32'd4;
        redirect.flush         = flush;
        redirect.flush_target  = f_target;
        redirect.br_taken      = taken;
        redirect.br_cancel     = taken;
        redirect.br_target     = b_target;
        step();
        redirect.flush     = 1'b0;
        redirect.br_taken  = 1'b0;
        redirect.br_cancel = 1'b0;
    endtask

    // old-path words may still trickle out until the target shows up
    task automatic follow_redirect(input string name, input addr_t target, input int n,
                                   input logic exp_ex, input ecode_t exp_ecode,
                                   input logic toggle);
        addr_t      old_pc;
        addr_t      new_pc;
        int         seen;
        int         cycles;
        logic       on_new;
        fetch_out_t o;
        old_pc = old_seq_pc;
        new_pc = target;
        seen   = 0;
        cycles = 0;
        on_new = 1'b0;
        while (seen < n) begin
            if (cycles == max_wait_cycles) begin
                abort_run($sformatf("%s: the redirected stream did not arrive in time", name));
            end
            step();
            cycles++;
            if (toggle) begin
                ds_allowin = random_ready();
            end
            while (out_q.size() > 0 && seen < n) begin
                o = out_q.pop_front();
                if (!on_new && o.pc == old_pc && o.pc != target) begin
                    old_pc = old_pc + 32'd4;
                end else begin
                    on_new = 1'b1;
                    check_output(name, o, new_pc, exp_ex, exp_ecode);
                    new_pc = new_pc + 32'd4;
                    seen++;
                end
            end
        end
        ds_allowin = 1'b1;
    endtask

    task automatic test_sequential();
        csr.crmd = crmd_value(2'd0, 1'b1, 1'b0);
        map_mode = map_direct;
        apply_reset();
        out_q.delete();
        wait_outputs("sequential", 12, 1'b0);
        for (int i = 0; i < 12; i++) begin
            check_output("sequential", out_q[i], reset_pc + 32'(4 * i), 1'b0, '0);
        end
    endtask

    task automatic test_backpressure();
        addr_t exp_pc;
        exp_pc = last_out_pc + 32'd4;
        out_q.delete();
        wait_outputs("backpressure", 40, 1'b1);
        ds_allowin = 1'b1;
        for (int i = 0; i < out_q.size(); i++) begin
            check_output("backpressure", out_q[i], exp_pc, 1'b0, '0);
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    // no request goes out while decode holds br_stall
    task automatic test_stall();
        addr_t exp_pc;
        step();
        redirect.br_stall = 1'b1;
        repeat (4) begin
            step();
            check_flag("branch stall req", 1'b0, inst_sram_req);
        end
        redirect.br_stall = 1'b0;
        exp_pc = last_out_pc + 32'd4;
        out_q.delete();
        wait_outputs("after stall", 6, 1'b0);
        for (int i = 0; i < out_q.size(); i++) begin
            check_output("after stall", out_q[i], exp_pc, 1'b0, '0);
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic test_branch();
        send_redirect(1'b0, 1'b1, '0, 32'h1c00_0400);
        follow_redirect("branch", 32'h1c00_0400, 8, 1'b0, '0, 1'b0);
    endtask

    task automatic test_flush();
        send_redirect(1'b1, 1'b1, 32'h1c00_2000, 32'h1c00_0800);
        follow_redirect("flush over branch", 32'h1c00_2000, 10, 1'b0, '0, 1'b1);
    endtask

    task automatic test_dmw();
        csr.crmd = crmd_value(2'd0, 1'b0, 1'b1);
        csr.dmw0 = dmw_value(3'b011, 3'b010);
        map_mode = map_dmw;
        map_pseg = 3'b010;
        send_redirect(1'b1, 1'b0, 32'h6000_1000, '0);
        follow_redirect("dmw0", 32'h6000_1000, 8, 1'b0, '0, 1'b0);
    endtask

    task automatic test_tlb();
        write_tlb(0, page_entry(32'h0040_3000, 20'h12345, 1'b0, 1'b1, 2'd0));
        write_tlb(1, page_entry(32'h0050_0000, 20'h0abcd, 1'b0, 1'b0, 2'd0));
        write_tlb(2, page_entry(32'h0080_0000, 20'h03c00, 1'b1, 1'b1, 2'd0));
        csr.crmd = crmd_value(2'd0, 1'b0, 1'b1);
        csr.dmw0 = '0;
        map_mode = map_tlb;
        map_ppn  = 20'h12345;
        map_huge = 1'b0;
        send_redirect(1'b1, 1'b0, 32'h0040_3000, '0);
        follow_redirect("tlb 4k page", 32'h0040_3000, 8, 1'b0, '0, 1'b1);
        map_ppn  = 20'h03c00;
        map_huge = 1'b1;
        send_redirect(1'b1, 1'b0, 32'h0081_2340, '0);
        follow_redirect("tlb 4m page", 32'h0081_2340, 8, 1'b0, '0, 1'b0);
        send_redirect(1'b1, 1'b0, 32'h0070_0000, '0);
        follow_redirect("tlb miss", 32'h0070_0000, 3, 1'b1, `ECODE_TLBR, 1'b0);
        send_redirect(1'b1, 1'b0, 32'h0050_0000, '0);
        follow_redirect("invalid page", 32'h0050_0000, 3, 1'b1, `ECODE_PIF, 1'b0);
        csr.crmd = crmd_value(2'd3, 1'b0, 1'b1);
        send_redirect(1'b1, 1'b0, 32'h0040_3000, '0);
        follow_redirect("privilege", 32'h0040_3000, 3, 1'b1, `ECODE_PPI, 1'b0);
    endtask

    task automatic test_misaligned();
        csr.crmd = crmd_value(2'd0, 1'b1, 1'b0);
        map_mode = map_direct;
        send_redirect(1'b1, 1'b0, 32'h1c00_1002, '0);
        follow_redirect("misaligned", 32'h1c00_1002, 3, 1'b1, `ECODE_ADE, 1'b0);
    endtask

    initial begin
        reset      = 1'b1;
        redirect   = '0;
        csr        = '0;
        ds_allowin = 1'b1;
        tlb_we     = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        rand_state = 32'd4783;
        map_mode   = map_direct;
        map_pseg   = '0;
        map_ppn    = '0;
        map_huge   = 1'b0;
        test_sequential();
        test_backpressure();
        test_stall();
        test_branch();
        test_flush();
        test_dmw();
        test_tlb();
        test_misaligned();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: bench/inst_mem_model.sv
`timescale 1ns/1ps

module inst_mem_model #(
    parameter int unsigned      seed = 4783,
    parameter fetch_pkg::inst_t key  = 32'h5a5a_0000
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req,
    input  fetch_pkg::addr_t addr,
    output logic             addr_ok,
    output logic             data_ok,
    output fetch_pkg::inst_t rdata
);
    import fetch_pkg::*;

    logic [31:0] rand_state;
    addr_t       pend_addr [$];
    int          pend_wait [$];
    int          accept_wait;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        addr_ok     = 1'b0;
        data_ok     = 1'b0;
        rdata       = '0;
        rand_state  = seed;
        accept_wait = 0;
    end

    // outputs change 1 ns after the edge that decides them
    always @(posedge clk) begin
        if (reset) begin
            pend_addr.delete();
            pend_wait.delete();
            accept_wait = 0;
            addr_ok <= #1 1'b0;
            data_ok <= #1 1'b0;
        end else begin
            data_ok <= #1 1'b0;
            // oldest request answers first, one per cycle
            if (pend_wait.size() > 0) begin
                if (pend_wait[0] <= 1) begin
                    data_ok <= #1 1'b1;
                    rdata   <= #1 pend_addr.pop_front() ^ key;
                    void'(pend_wait.pop_front());
                end else begin
                    pend_wait[0] = pend_wait[0] - 1;
                end
            end
            if (req && addr_ok) begin
                rand_state = lcg_step(rand_state);
                pend_addr.push_back(addr);
                pend_wait.push_back(1 + int'(rand_state[23:16]) % 3);
                rand_state  = lcg_step(rand_state);
                accept_wait = int'(rand_state[23:16]) % 3;
                addr_ok <= #1 (accept_wait == 0);
            end else if (!addr_ok) begin
                if (accept_wait <= 1) begin
                    addr_ok <= #1 1'b1;
                end else begin
                    accept_wait = accept_wait - 1;
                end
            end
        end
    end

endmodule

// File: include/csr_fields.svh
`ifndef CSR_FIELDS_SVH
`define CSR_FIELDS_SVH

// crmd
`define CRMD_PLV   1:0
`define CRMD_DA    3
`define CRMD_PG    4

// dmw0 / dmw1
`define DMW_PLV0   0
`define DMW_PLV3   3
`define DMW_PSEG   27:25
`define DMW_VSEG   31:29

`define ASID_ASID  9:0

// fetch exception codes
`define ECODE_ADE  6'h08
`define ECODE_TLBR 6'h3f
`define ECODE_PIF  6'h03
`define ECODE_PPI  6'h07

`endif

// File: logic/addr_translate.sv
`timescale 1ns/1ps
`include "csr_fields.svh"

module addr_translate (
    input  fetch_pkg::addr_t      vaddr,
    input  fetch_pkg::csr_view_t  csr,
    input  logic                  tlb_hit,
    input  fetch_pkg::tlb_entry_t tlb_entry,
    output fetch_pkg::vppn_t      tlb_vppn,
    output fetch_pkg::asid_t      tlb_asid,
    output fetch_pkg::xlate_t     xlate
);
    import fetch_pkg::*;

    plv_t  cur_plv;
    logic  direct;
    logic  paging;
    logic  dmw0_hit;
    logic  dmw1_hit;
    logic  tlb_map;
    addr_t dmw_pa;
    addr_t tlb_pa;
    logic  ex_ade;
    logic  ex_tlbr;
    logic  ex_pif;
    logic  ex_ppi;

    // window is open for this plv and the top three bits match
    function automatic logic dmw_match(input logic [31:0] dmw, input plv_t plv,
                                       input addr_t va);
        logic plv_ok;
        if (plv == 2'd0) begin
            plv_ok = dmw[`DMW_PLV0];
        end else if (plv == 2'd3) begin
            plv_ok = dmw[`DMW_PLV3];
        end else begin
            plv_ok = 1'b0;
        end
        return plv_ok && (dmw[`DMW_VSEG] == va[31:29]);
    endfunction

    assign cur_plv = csr.crmd[`CRMD_PLV];
    assign direct  = csr.crmd[`CRMD_DA];
    assign paging  = csr.crmd[`CRMD_PG] && !direct;

    assign dmw0_hit = !direct && dmw_match(csr.dmw0, cur_plv, vaddr);
    assign dmw1_hit = !direct && dmw_match(csr.dmw1, cur_plv, vaddr);

    // dmw0 has priority
    assign dmw_pa = dmw0_hit ? {csr.dmw0[`DMW_PSEG], vaddr[28:0]}
                             : {csr.dmw1[`DMW_PSEG], vaddr[28:0]};

    // tlb lookup key
    assign tlb_vppn = vaddr[31:13];
    assign tlb_asid = csr.asid[`ASID_ASID];

    assign tlb_pa = tlb_entry.huge ? {tlb_entry.ppn[19:10], vaddr[21:0]}
                                   : {tlb_entry.ppn, vaddr[11:0]};

    assign tlb_map = paging && !dmw0_hit && !dmw1_hit;

    assign ex_ade  = (vaddr[1:0] != 2'b00) || (paging && vaddr[31]);
    assign ex_tlbr = tlb_map && !tlb_hit;
    assign ex_pif  = tlb_map && tlb_hit && !tlb_entry.v;
    assign ex_ppi  = tlb_map && tlb_hit && (cur_plv > tlb_entry.plv);

    always_comb begin
        if (direct) begin
            xlate.pa = vaddr;
        end else if (dmw0_hit || dmw1_hit) begin
            xlate.pa = dmw_pa;
        end else begin
            xlate.pa = tlb_pa;
        end

        xlate.ex = ex_ade || ex_tlbr || ex_pif || ex_ppi;

        if (ex_ade) begin
            xlate.ecode = `ECODE_ADE;
        end else if (ex_tlbr) begin
            xlate.ecode = `ECODE_TLBR;
        end else if (ex_pif) begin
            xlate.ecode = `ECODE_PIF;
        end else if (ex_ppi) begin
            xlate.ecode = `ECODE_PPI;
        end else begin
            xlate.ecode = '0;
        end
    end

endmodule

// File: logic/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer #(
    parameter fetch_pkg::addr_t reset_pc = 32'h1c00_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::xlate_t     xlate,
    input  fetch_pkg::addr_t      next_pc,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  ds_allowin,
    input  logic                  inst_sram_addr_ok,
    input  logic                  inst_sram_data_ok,
    input  fetch_pkg::inst_t      inst_sram_rdata,
    output fetch_pkg::addr_t      fs_pc,
    output logic                  req_accepted,
    output logic                  inst_sram_req,
    output fetch_pkg::addr_t      inst_sram_addr,
    output logic                  fs_to_ds_valid,
    output fetch_pkg::fetch_out_t fs_to_ds
);
    import fetch_pkg::*;

    logic   fs_valid;
    logic   held_valid;
    inst_t  held_inst;
    logic   cancel_r;
    logic   fs_ex;
    ecode_t fs_ecode;
    logic   kill;
    logic   data_hit;
    logic   fs_ready_go;
    logic   fs_allowin;

    assign kill = redirect.br_cancel || redirect.flush;

    // a response while cancel_r is set belongs to the old path
    assign data_hit    = inst_sram_data_ok && !cancel_r;
    assign fs_ready_go = held_valid || (fs_valid && data_hit);
    assign fs_allowin  = !fs_valid || (fs_ready_go && ds_allowin);

    assign inst_sram_req  = fs_allowin && !cancel_r && !redirect.br_stall;
    assign inst_sram_addr = xlate.pa;
    assign req_accepted   = inst_sram_req && inst_sram_addr_ok;

    assign fs_to_ds_valid = fs_valid && fs_ready_go && ds_allowin && !kill;
    assign fs_to_ds.pc    = fs_pc;
    assign fs_to_ds.inst  = held_valid ? held_inst : inst_sram_rdata;
    assign fs_to_ds.ex    = fs_ex;
    assign fs_to_ds.ecode = fs_ecode;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= req_accepted;
        end else if (kill) begin
            fs_valid <= 1'b0;
        end
    end

    // so that the first sequential pc is reset_pc
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= reset_pc - 32'd4;
        end else if (req_accepted) begin
            fs_pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (req_accepted) begin
            fs_ex    <= xlate.ex;
            fs_ecode <= xlate.ecode;
        end
    end

    // decode not ready when the word arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (kill || ds_allowin) begin
            held_valid <= 1'b0;
        end else if (fs_valid && data_hit) begin
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && data_hit && !ds_allowin) begin
            held_inst <= inst_sram_rdata;
        end
    end

    // redirect with a response still on its way
    always_ff @(posedge clk) begin
        if (reset) begin
            cancel_r <= 1'b0;
        end else if (kill && fs_valid && !held_valid && !data_hit) begin
            cancel_r <= 1'b1;
        end else if (inst_sram_data_ok) begin
            cancel_r <= 1'b0;
        end
    end

    a_data_ok_owned: assert property (@(posedge clk) disable iff (reset)
        inst_sram_data_ok |-> cancel_r || (fs_valid && !held_valid))
        else $error("fetch_buffer: data_ok without an outstanding request");

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [9:0]  asid_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [1:0]  plv_t;

    // from decode (branch) and writeback (flush)
    typedef struct packed {
        logic  br_stall;
        logic  br_taken;
        logic  br_cancel;
        addr_t br_target;
        logic  flush;
        addr_t flush_target;
    } redirect_t;

    typedef struct packed {
        logic [31:0] crmd;
        logic [31:0] dmw0;
        logic [31:0] dmw1;
        logic [31:0] asid;
    } csr_view_t;

    // huge set means a 4 MB page
    typedef struct packed {
        vppn_t vppn;
        logic  huge;
        logic  g;
        asid_t asid;
        logic  e;
        ppn_t  ppn;
        plv_t  plv;
        logic  v;
    } tlb_entry_t;

    typedef struct packed {
        addr_t  pa;
        logic   ex;
        ecode_t ecode;
    } xlate_t;

    typedef struct packed {
        addr_t  pc;
        inst_t  inst;
        logic   ex;
        ecode_t ecode;
    } fetch_out_t;

endpackage

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter fetch_pkg::addr_t reset_pc    = 32'h1c00_0000,
    parameter int               tlb_entries = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  fetch_pkg::redirect_t           redirect,
    input  fetch_pkg::csr_view_t           csr,
    input  logic                           ds_allowin,
    input  logic                           tlb_we,
    input  logic [$clog2(tlb_entries)-1:0] tlb_windex,
    input  fetch_pkg::tlb_entry_t          tlb_wentry,
    input  logic                           inst_sram_addr_ok,
    input  logic                           inst_sram_data_ok,
    input  fetch_pkg::inst_t               inst_sram_rdata,
    output logic                           fs_to_ds_valid,
    output fetch_pkg::fetch_out_t          fs_to_ds,
    output logic                           inst_sram_req,
    output fetch_pkg::addr_t               inst_sram_addr
);
    import fetch_pkg::*;

    addr_t      next_pc;
    addr_t      fs_pc;
    logic       req_accepted;
    vppn_t      tlb_vppn;
    asid_t      tlb_asid;
    logic       tlb_hit;
    tlb_entry_t tlb_entry;
    xlate_t     xlate;

    pc_select #(
        .reset_pc (reset_pc)
    ) u_pc_select (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .fs_pc        (fs_pc),
        .req_accepted (req_accepted),
        .next_pc      (next_pc)
    );

    addr_translate u_addr_translate (
        .vaddr     (next_pc),
        .csr       (csr),
        .tlb_hit   (tlb_hit),
        .tlb_entry (tlb_entry),
        .tlb_vppn  (tlb_vppn),
        .tlb_asid  (tlb_asid),
        .xlate     (xlate)
    );

    itlb #(
        .tlb_entries (tlb_entries)
    ) u_itlb (
        .clk     (clk),
        .reset   (reset),
        .we      (tlb_we),
        .windex  (tlb_windex),
        .wentry  (tlb_wentry),
        .s_vppn  (tlb_vppn),
        .s_asid  (tlb_asid),
        .s_hit   (tlb_hit),
        .s_entry (tlb_entry)
    );

    fetch_buffer #(
        .reset_pc (reset_pc)
    ) u_fetch_buffer (
        .clk               (clk),
        .reset             (reset),
        .xlate             (xlate),
        .next_pc           (next_pc),
        .redirect          (redirect),
        .ds_allowin        (ds_allowin),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .fs_pc             (fs_pc),
        .req_accepted      (req_accepted),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr    (inst_sram_addr),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds          (fs_to_ds)
    );

endmodule

// File: logic/itlb.sv
`timescale 1ns/1ps

module itlb #(
    parameter int tlb_entries = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           we,
    input  logic [$clog2(tlb_entries)-1:0] windex,
    input  fetch_pkg::tlb_entry_t          wentry,
    input  fetch_pkg::vppn_t               s_vppn,
    input  fetch_pkg::asid_t               s_asid,
    output logic                           s_hit,
    output fetch_pkg::tlb_entry_t          s_entry
);
    import fetch_pkg::*;

    tlb_entry_t             entries [tlb_entries];
    logic [tlb_entries-1:0] exists;
    logic [tlb_entries-1:0] hit_vec;

    // after reset no entry exists
    always_ff @(posedge clk) begin
        if (reset) begin
            exists <= '0;
        end else if (we) begin
            exists[windex] <= wentry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            entries[windex] <= wentry;
        end
    end

    // huge pages ignore vaddr[21:13], i.e. vppn[8:0]
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            hit_vec[i] = exists[i]
                && (entries[i].huge ? (entries[i].vppn[18:9] == s_vppn[18:9])
                                    : (entries[i].vppn == s_vppn))
                && (entries[i].g || (entries[i].asid == s_asid));
        end
    end

    assign s_hit = |hit_vec;

    // one-hot select of the matching entry
    always_comb begin
        s_entry = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (hit_vec[i]) begin
                s_entry = s_entry | entries[i];
            end
        end
    end

    // software must never load overlapping entries
    a_single_hit: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_vec))
        else $error("itlb: more than one entry matches the search key");

endmodule

// File: logic/pc_select.sv
`timescale 1ns/1ps

module pc_select #(
    parameter fetch_pkg::addr_t reset_pc = 32'h1c00_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t redirect,
    input  fetch_pkg::addr_t     fs_pc,
    input  logic                 req_accepted,
    output fetch_pkg::addr_t     next_pc
);
    import fetch_pkg::*;

    logic  buf_valid;
    addr_t buf_target;
    addr_t seq_pc;

    // redirect seen while no request got through waits here
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (req_accepted) begin
            buf_valid <= 1'b0;
        end else if (redirect.flush || redirect.br_taken) begin
            buf_valid <= 1'b1;
        end else if (redirect.br_stall) begin
            buf_valid <= 1'b0;
        end
    end

    // flush target beats a branch target
    always_ff @(posedge clk) begin
        if (!req_accepted) begin
            if (redirect.flush) begin
                buf_target <= redirect.flush_target;
            end else if (redirect.br_taken) begin
                buf_target <= redirect.br_target;
            end
        end
    end

    assign seq_pc = fs_pc + 32'd4;

    always_comb begin
        if (redirect.flush) begin
            next_pc = redirect.flush_target;
        end else if (buf_valid) begin
            next_pc = buf_target;
        end else if (redirect.br_taken) begin
            next_pc = redirect.br_target;
        end else begin
            next_pc = seq_pc;
        end
    end

    // a buffered redirect is what the next accepted fetch goes to
    a_buf_consumed: assert property (@(posedge clk) disable iff (reset)
        buf_valid && req_accepted && !redirect.flush |=> fs_pc == $past(buf_target))
        else $error("pc_select: accepted fetch did not use the buffered redirect");

    // fs_pc comes out of reset one word below the boot address
    a_first_fetch: assert property (@(posedge clk)
        $fell(reset) && !redirect.flush && !redirect.br_taken |-> next_pc == reset_pc)
        else $error("pc_select: first fetch address is not reset_pc");

endmodule

// File: sources.f
+incdir+include
logic/fetch_pkg.sv
logic/pc_select.sv
logic/addr_translate.sv
logic/itlb.sv
logic/fetch_buffer.sv
logic/fetch_unit.sv
bench/inst_mem_model.sv
bench/fetch_unit_tb.sv
